// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    parameter int XLEN = 32; // register width

    // major opcodes of the kept integer subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_NOP    = 7'b0000000; // all-zero word

    localparam logic [2:0] F3_ADD  = 3'b000; // also sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl or sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

    // one instruction word seen as R/I fields or as S/B fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;    // or low bits of the I immediate
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } sb;
    } inst_u;

endpackage

`default_nettype wire

// File: hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    parameter int OPW = 4; // alu operation code width

    localparam logic [OPW-1:0] OP_ADD  = 4'd0;
    localparam logic [OPW-1:0] OP_SUB  = 4'd1;
    localparam logic [OPW-1:0] OP_SLL  = 4'd2;
    localparam logic [OPW-1:0] OP_SRL  = 4'd3;
    localparam logic [OPW-1:0] OP_SRA  = 4'd4;
    localparam logic [OPW-1:0] OP_SLT  = 4'd5;
    localparam logic [OPW-1:0] OP_SLTU = 4'd6;
    localparam logic [OPW-1:0] OP_XOR  = 4'd7;
    localparam logic [OPW-1:0] OP_OR   = 4'd8;
    localparam logic [OPW-1:0] OP_AND  = 4'd9;
    localparam logic [OPW-1:0] OP_PASS = 4'd10; // result is operand b

    // next program counter source
    localparam logic [1:0] NPC_SEQ    = 2'd0; // pc + 4
    localparam logic [1:0] NPC_BRANCH = 2'd1; // pc + imm if taken
    localparam logic [1:0] NPC_JAL    = 2'd2;
    localparam logic [1:0] NPC_JALR   = 2'd3;

endpackage

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire                         in_valid_i,
    output logic                        in_ready_o,
    input  wire rv_isa_pkg::inst_u      inst_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  pc_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  rs1_data_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  rs2_data_i,
    output logic                        dec_valid_o,
    input  wire                         dec_ready_i,
    output logic [exec_pkg::OPW-1:0]    dec_op_o,
    output logic [rv_isa_pkg::XLEN-1:0] dec_a_o,
    output logic [rv_isa_pkg::XLEN-1:0] dec_b_o,
    output logic [rv_isa_pkg::XLEN-1:0] dec_pc_o,
    output logic [rv_isa_pkg::XLEN-1:0] dec_imm_o,
    output logic [rv_isa_pkg::XLEN-1:0] dec_rs1_o,
    output logic [rv_isa_pkg::XLEN-1:0] dec_rs2_o,
    output logic [1:0]                  dec_npc_sel_o,
    output logic [2:0]                  dec_br_f3_o,
    output logic                        dec_rd_we_o,
    output logic [4:0]                  dec_rd_addr_o,
    output logic                        dec_illegal_o
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [OPW-1:0]  op_c;
    logic [XLEN-1:0] a_c;
    logic [XLEN-1:0] b_c;
    logic [XLEN-1:0] imm_c;
    logic [1:0]      npc_sel_c;
    logic            rd_we_c;
    logic            illegal_c;

    assign in_ready_o = !dec_valid_o || dec_ready_i; // empty or draining

    assign imm_i = {{20{inst_i.r.funct7[6]}}, inst_i.r.funct7, inst_i.r.rs2};
    assign imm_b = {{20{inst_i.sb.imm_hi[6]}}, inst_i.sb.imm_lo[0], inst_i.sb.imm_hi[5:0],
                    inst_i.sb.imm_lo[4:1], 1'b0};
    assign imm_u = {inst_i.r.funct7, inst_i.r.rs2, inst_i.r.rs1, inst_i.r.funct3, 12'h000};
    assign imm_j = {{12{inst_i.r.funct7[6]}}, inst_i.r.rs1, inst_i.r.funct3, inst_i.r.rs2[0],
                    inst_i.r.funct7[5:0], inst_i.r.rs2[4:1], 1'b0};

    always_comb begin
        op_c      = OP_ADD;
        a_c       = rs1_data_i;
        b_c       = rs2_data_i;
        imm_c     = imm_i;
        npc_sel_c = NPC_SEQ;
        rd_we_c   = 1'b0;
        illegal_c = 1'b0;
        case (inst_i.r.opcode)
            OPC_OP_IMM: begin
                b_c     = imm_i; // shamt sits in the low 5 bits
                rd_we_c = 1'b1;
                case (inst_i.r.funct3)
                    F3_ADD:  op_c = OP_ADD;
                    F3_SLT:  op_c = OP_SLT;
                    F3_SLTU: op_c = OP_SLTU;
                    F3_XOR:  op_c = OP_XOR;
                    F3_OR:   op_c = OP_OR;
                    F3_SLL: begin
                        op_c      = OP_SLL;
                        illegal_c = (inst_i.r.funct7 != F7_BASE);
                    end
                    F3_SR: begin
                        if (inst_i.r.funct7 == F7_BASE) begin
                            op_c = OP_SRL;
                        end else if (inst_i.r.funct7 == F7_ALT) begin
                            op_c = OP_SRA;
                        end else begin
                            illegal_c = 1'b1;
                        end
                    end
                    default: op_c = OP_AND;
                endcase
            end
            OPC_OP: begin
                rd_we_c = 1'b1;
                if (inst_i.r.funct7 == F7_BASE) begin
                    case (inst_i.r.funct3)
                        F3_ADD:  op_c = OP_ADD;
                        F3_SLL:  op_c = OP_SLL;
                        F3_SLT:  op_c = OP_SLT;
                        F3_SLTU: op_c = OP_SLTU;
                        F3_XOR:  op_c = OP_XOR;
                        F3_SR:   op_c = OP_SRL;
                        F3_OR:   op_c = OP_OR;
                        default: op_c = OP_AND;
                    endcase
                end else if (inst_i.r.funct7 == F7_ALT) begin
                    case (inst_i.r.funct3)
                        F3_ADD:  op_c = OP_SUB;
                        F3_SR:   op_c = OP_SRA;
                        default: illegal_c = 1'b1; // no other alt forms
                    endcase
                end else begin
                    illegal_c = 1'b1;
                end
            end
            OPC_LUI: begin
                op_c    = OP_PASS;
                b_c     = imm_u;
                rd_we_c = 1'b1;
            end
            OPC_AUIPC: begin
                a_c     = pc_i;
                b_c     = imm_u;
                rd_we_c = 1'b1;
            end
            OPC_JAL: begin
                a_c       = pc_i; // link value pc + 4
                b_c       = 32'd4;
                imm_c     = imm_j;
                npc_sel_c = NPC_JAL;
                rd_we_c   = 1'b1;
            end
            OPC_JALR: begin
                a_c       = pc_i;
                b_c       = 32'd4;
                npc_sel_c = NPC_JALR;
                rd_we_c   = 1'b1;
                illegal_c = (inst_i.r.funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm_c     = imm_b;
                npc_sel_c = NPC_BRANCH;
                illegal_c = (inst_i.sb.funct3 == 3'b010) || (inst_i.sb.funct3 == 3'b011);
            end
            OPC_FENCE, OPC_NOP: ; // only step the pc
            default: illegal_c = 1'b1;
        endcase
        if (illegal_c) begin
            rd_we_c   = 1'b0;
            npc_sel_c = NPC_SEQ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            dec_valid_o <= in_valid_i;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            dec_op_o      <= op_c;
            dec_a_o       <= a_c;
            dec_b_o       <= b_c;
            dec_pc_o      <= pc_i;
            dec_imm_o     <= imm_c;
            dec_rs1_o     <= rs1_data_i;
            dec_rs2_o     <= rs2_data_i;
            dec_npc_sel_o <= npc_sel_c;
            dec_br_f3_o   <= inst_i.sb.funct3;
            dec_rd_we_o   <= rd_we_c;
            dec_rd_addr_o <= inst_i.r.rd;
            dec_illegal_o <= illegal_c;
        end
    end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire                         dec_valid_i,
    output logic                        dec_ready_o,
    input  wire [exec_pkg::OPW-1:0]     dec_op_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  dec_a_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  dec_b_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  dec_pc_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  dec_imm_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  dec_rs1_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  dec_rs2_i,
    input  wire [1:0]                   dec_npc_sel_i,
    input  wire [2:0]                   dec_br_f3_i,
    input  wire                         dec_rd_we_i,
    input  wire [4:0]                   dec_rd_addr_i,
    input  wire                         dec_illegal_i,
    output logic                        out_valid_o,
    input  wire                         out_ready_i,
    output logic                        rd_we_o,
    output logic [4:0]                  rd_addr_o,
    output logic [rv_isa_pkg::XLEN-1:0] rd_data_o,
    output logic [rv_isa_pkg::XLEN-1:0] pc_next_o,
    output logic                        illegal_o
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_res;
    logic            br_eq;
    logic            br_lt;
    logic            br_ltu;
    logic            taken;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] imm_tgt;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] npc_c;

    assign dec_ready_o = !out_valid_o || out_ready_i;

    assign shamt = dec_b_i[4:0];

    always_comb begin
        case (dec_op_i)
            OP_ADD:  alu_res = dec_a_i + dec_b_i;
            OP_SUB:  alu_res = dec_a_i - dec_b_i;
            OP_SLL:  alu_res = dec_a_i << shamt;
            OP_SRL:  alu_res = dec_a_i >> shamt;
            OP_SRA:  alu_res = $signed(dec_a_i) >>> shamt; // sign fills from the left
            OP_SLT:  alu_res = {31'b0, $signed(dec_a_i) < $signed(dec_b_i)};
            OP_SLTU: alu_res = {31'b0, dec_a_i < dec_b_i};
            OP_XOR:  alu_res = dec_a_i ^ dec_b_i;
            OP_OR:   alu_res = dec_a_i | dec_b_i;
            OP_AND:  alu_res = dec_a_i & dec_b_i;
            default: alu_res = dec_b_i; // pass for lui
        endcase
    end

    // branch compare always works on the register pair
    assign br_eq  = (dec_rs1_i == dec_rs2_i);
    assign br_lt  = ($signed(dec_rs1_i) < $signed(dec_rs2_i));
    assign br_ltu = (dec_rs1_i < dec_rs2_i);

    always_comb begin
        case (dec_br_f3_i)
            F3_BEQ:  taken = br_eq;
            F3_BNE:  taken = !br_eq;
            F3_BLT:  taken = br_lt;
            F3_BGE:  taken = !br_lt;
            F3_BLTU: taken = br_ltu;
            F3_BGEU: taken = !br_ltu;
            default: taken = 1'b0; // decode flags these illegal
        endcase
    end

    assign seq_pc   = dec_pc_i + 32'd4;
    assign imm_tgt  = dec_pc_i + dec_imm_i;
    assign jalr_sum = dec_rs1_i + dec_imm_i;

    always_comb begin
        case (dec_npc_sel_i)
            NPC_BRANCH: npc_c = taken ? imm_tgt : seq_pc;
            NPC_JAL:    npc_c = imm_tgt;
            NPC_JALR:   npc_c = {jalr_sum[XLEN-1:1], 1'b0}; // bit 0 cleared
            default:    npc_c = seq_pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
        end else if (dec_ready_o) begin
            out_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i && dec_ready_o) begin
            rd_we_o   <= dec_rd_we_i;
            rd_addr_o <= dec_rd_addr_i;
            rd_data_o <= alu_res;
            pc_next_o <= npc_c;
            illegal_o <= dec_illegal_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exec_core.sv
`timescale 1ns/10ps
`default_nettype none

module exec_core (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire                         in_valid_i,
    output logic                        in_ready_o,
    input  wire rv_isa_pkg::inst_u      inst_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  pc_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  rs1_data_i,
    input  wire [rv_isa_pkg::XLEN-1:0]  rs2_data_i,
    output logic                        out_valid_o,
    input  wire                         out_ready_i,
    output logic                        rd_we_o,
    output logic [4:0]                  rd_addr_o,
    output logic [rv_isa_pkg::XLEN-1:0] rd_data_o,
    output logic [rv_isa_pkg::XLEN-1:0] pc_next_o,
    output logic                        illegal_o
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    wire            dec_valid;
    wire            dec_ready;   // ripples back to in_ready_o
    wire [OPW-1:0]  dec_op;
    wire [XLEN-1:0] dec_a;
    wire [XLEN-1:0] dec_b;
    wire [XLEN-1:0] dec_pc;
    wire [XLEN-1:0] dec_imm;
    wire [XLEN-1:0] dec_rs1;
    wire [XLEN-1:0] dec_rs2;
    wire [1:0]      dec_npc_sel;
    wire [2:0]      dec_br_f3;
    wire            dec_rd_we;
    wire [4:0]      dec_rd_addr;
    wire            dec_illegal;

    decode_stage u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .dec_valid_o   (dec_valid),
        .dec_ready_i   (dec_ready),
        .dec_op_o      (dec_op),
        .dec_a_o       (dec_a),
        .dec_b_o       (dec_b),
        .dec_pc_o      (dec_pc),
        .dec_imm_o     (dec_imm),
        .dec_rs1_o     (dec_rs1),
        .dec_rs2_o     (dec_rs2),
        .dec_npc_sel_o (dec_npc_sel),
        .dec_br_f3_o   (dec_br_f3),
        .dec_rd_we_o   (dec_rd_we),
        .dec_rd_addr_o (dec_rd_addr),
        .dec_illegal_o (dec_illegal)
    );

    execute_stage u_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .dec_valid_i   (dec_valid),
        .dec_ready_o   (dec_ready),
        .dec_op_i      (dec_op),
        .dec_a_i       (dec_a),
        .dec_b_i       (dec_b),
        .dec_pc_i      (dec_pc),
        .dec_imm_i     (dec_imm),
        .dec_rs1_i     (dec_rs1),
        .dec_rs2_i     (dec_rs2),
        .dec_npc_sel_i (dec_npc_sel),
        .dec_br_f3_i   (dec_br_f3),
        .dec_rd_we_i   (dec_rd_we),
        .dec_rd_addr_i (dec_rd_addr),
        .dec_illegal_i (dec_illegal),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .rd_we_o       (rd_we_o),
        .rd_addr_o     (rd_addr_o),
        .rd_data_o     (rd_data_o),
        .pc_next_o     (pc_next_o),
        .illegal_o     (illegal_o)
    );

endmodule

`default_nettype wire

// File: testbench/exec_core_sva.sv
`timescale 1ns/10ps
`default_nettype none

module exec_core_sva (
    input wire                        clk,
    input wire                        reset_i,
    input wire                        in_ready_i,
    input wire                        out_valid_i,
    input wire                        out_ready_i,
    input wire                        rd_we_i,
    input wire [4:0]                  rd_addr_i,
    input wire [rv_isa_pkg::XLEN-1:0] rd_data_i,
    input wire [rv_isa_pkg::XLEN-1:0] pc_next_i,
    input wire                        illegal_i
);
    int fail_count = 0; // failed assertion count

    // a stalled output item must not move or change
    hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(rd_we_i)
            && $stable(rd_addr_i) && $stable(rd_data_i)
            && $stable(pc_next_i) && $stable(illegal_i))
        else begin
            $error("output item changed while out_ready_i was low");
            fail_count++;
        end

    empty_after_reset: assert property (@(posedge clk)
        reset_i |=> !out_valid_i && in_ready_i)
        else begin
            $error("pipeline not empty after reset");
            fail_count++;
        end

    no_write_when_illegal: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_i && illegal_i |-> !rd_we_i)
        else begin
            $error("illegal item with register write enabled");
            fail_count++;
        end

endmodule

bind exec_core exec_core_sva u_sva (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_we_i     (rd_we_o),
    .rd_addr_i   (rd_addr_o),
    .rd_data_i   (rd_data_o),
    .pc_next_i   (pc_next_o),
    .illegal_i   (illegal_o)
);

`default_nettype wire

// File: testbench/tb_exec_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_core;
    import rv_isa_pkg::*;

    localparam int MAX_ITEMS      = 64;
    localparam int TIMEOUT_CYCLES = 200;

    logic            clk;
    logic            reset_i;
    logic            in_valid_i;
    wire             in_ready_o;
    inst_u           inst_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] rs1_data_i;
    logic [XLEN-1:0] rs2_data_i;
    wire             out_valid_o;
    logic            out_ready_i;
    wire             rd_we_o;
    wire [4:0]       rd_addr_o;
    wire [XLEN-1:0]  rd_data_o;
    wire [XLEN-1:0]  pc_next_o;
    wire             illegal_o;

    // one entry per pattern line
    logic [XLEN-1:0] pat_inst [MAX_ITEMS];
    logic [XLEN-1:0] pat_pc [MAX_ITEMS];
    logic [XLEN-1:0] pat_rs1 [MAX_ITEMS];
    logic [XLEN-1:0] pat_rs2 [MAX_ITEMS];
    logic            pat_we [MAX_ITEMS];
    logic [4:0]      pat_rd [MAX_ITEMS];
    logic [XLEN-1:0] pat_data [MAX_ITEMS];
    logic [XLEN-1:0] pat_npc [MAX_ITEMS];
    logic            pat_ill [MAX_ITEMS];
    logic            pat_stall [MAX_ITEMS];

    int n_items;
    int received;
    int err_count;
    int timeout_count;
    int sva_errors;
    int stall_cycles;
    int exp_q [$]; // pattern indices of accepted items in arrival order

    exec_core dut0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .rd_we_o     (rd_we_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_o   (rd_data_o),
        .pc_next_o   (pc_next_o),
        .illegal_o   (illegal_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic read_patterns();
        int              fd;
        int              code;
        string           line;
        logic [XLEN-1:0] c_inst;
        logic [XLEN-1:0] c_pc;
        logic [XLEN-1:0] c_rs1;
        logic [XLEN-1:0] c_rs2;
        logic [XLEN-1:0] c_we;
        logic [XLEN-1:0] c_rd;
        logic [XLEN-1:0] c_data;
        logic [XLEN-1:0] c_npc;
        logic [XLEN-1:0] c_ill;
        logic [XLEN-1:0] c_stall;
        fd = $fopen("testbench/exec_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file testbench/exec_patterns.txt");
            err_count++;
            return;
        end
        while (!$feof(fd) && n_items < MAX_ITEMS) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", c_inst, c_pc,
                               c_rs1, c_rs2, c_we, c_rd, c_data, c_npc, c_ill, c_stall);
                if (code == 10) begin
                    pat_inst[n_items]  = c_inst;
                    pat_pc[n_items]    = c_pc;
                    pat_rs1[n_items]   = c_rs1;
                    pat_rs2[n_items]   = c_rs2;
                    pat_we[n_items]    = c_we[0];
                    pat_rd[n_items]    = c_rd[4:0];
                    pat_data[n_items]  = c_data;
                    pat_npc[n_items]   = c_npc;
                    pat_ill[n_items]   = c_ill[0];
                    pat_stall[n_items] = c_stall[0];
                    n_items++;
                end else begin
                    $display("pattern line could not be read: %s", line);
                    err_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_wb(input int idx, input logic we, input logic [4:0] addr,
                            input logic [XLEN-1:0] data, input logic exp_we,
                            input logic [4:0] exp_addr, input logic [XLEN-1:0] exp_data);
        if (we !== exp_we) begin
            $display("ERROR %0t: item %0d rd_we got %b expected %b", $time, idx, we, exp_we);
            err_count++;
        end else if (exp_we && (addr !== exp_addr || data !== exp_data)) begin
            $display("ERROR %0t: item %0d writeback got x%0d=%h expected x%0d=%h",
                     $time, idx, addr, data, exp_addr, exp_data);
            err_count++;
        end
    endtask

    task automatic check_pc(input int idx, input logic [XLEN-1:0] pc_next,
                            input logic [XLEN-1:0] exp_pc);
        if (pc_next !== exp_pc) begin
            $display("ERROR %0t: item %0d pc_next got %h expected %h",
                     $time, idx, pc_next, exp_pc);
            err_count++;
        end
    endtask

    task automatic check_illegal(input int idx, input logic illegal, input logic exp_ill);
        if (illegal !== exp_ill) begin
            $display("ERROR %0t: item %0d illegal got %b expected %b",
                     $time, idx, illegal, exp_ill);
            err_count++;
        end
    endtask

    // starts and ends on a falling edge
    task automatic drive_items();
        int gap;
        int wait_cycles;
        bit accepted;
        for (int i = 0; i < n_items; i++) begin
            gap = $urandom % 3;
            repeat (gap) begin
                in_valid_i = 1'b0;
                @(negedge clk);
            end
            in_valid_i = 1'b1;
            inst_i     = pat_inst[i];
            pc_i       = pat_pc[i];
            rs1_data_i = pat_rs1[i];
            rs2_data_i = pat_rs2[i];
            accepted    = 1'b0;
            wait_cycles = 0;
            while (!accepted) begin
                #1; // ready settles after the falling edge
                if (in_ready_o) begin
                    accepted = 1'b1;
                    exp_q.push_back(i);
                    if (pat_stall[i]) stall_cycles = 4;
                end else if (wait_cycles == TIMEOUT_CYCLES) begin
                    $display("timeout: input item %0d was never accepted", i);
                    timeout_count++;
                    in_valid_i = 1'b0;
                    return;
                end
                wait_cycles++;
                @(negedge clk);
            end
        end
        in_valid_i = 1'b0;
    endtask

    task automatic collect_items();
        int idle_cycles;
        int idx;
        idle_cycles = 0;
        while (received < n_items) begin
            @(negedge clk);
            if (stall_cycles > 0) begin
                out_ready_i = 1'b0;
                stall_cycles--;
            end else begin
                out_ready_i = ($urandom % 4) != 0;
            end
            #1; // outputs hold until the next rising edge
            if (out_valid_o && out_ready_i) begin
                idle_cycles = 0;
                received++;
                if (exp_q.size() == 0) begin
                    $display("ERROR %0t: output item with no accepted input", $time);
                    err_count++;
                end else begin
                    idx = exp_q.pop_front();
                    check_wb(idx, rd_we_o, rd_addr_o, rd_data_o,
                             pat_we[idx], pat_rd[idx], pat_data[idx]);
                    check_pc(idx, pc_next_o, pat_npc[idx]);
                    check_illegal(idx, illegal_o, pat_ill[idx]);
                end
            end else if (idle_cycles == TIMEOUT_CYCLES) begin
                $display("timeout: only %0d of %0d items came out", received, n_items);
                timeout_count++;
                return;
            end else begin
                idle_cycles++;
            end
        end
    endtask

    task automatic drain_check();
        repeat (4) begin
            @(negedge clk);
            out_ready_i = 1'b1;
            #1;
            if (out_valid_o) begin
                $display("ERROR %0t: extra output item after the last one", $time);
                err_count++;
            end
        end
        if (exp_q.size() != 0) begin
            $display("ERROR %0t: %0d accepted items never came out", $time, exp_q.size());
            err_count++;
        end
    endtask

    initial begin
        void'($urandom(32'he2d6_5370));
        reset_i       = 1'b1;
        in_valid_i    = 1'b0;
        inst_i        = '0;
        pc_i          = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        out_ready_i   = 1'b0;
        n_items       = 0;
        received      = 0;
        err_count     = 0;
        timeout_count = 0;
        stall_cycles  = 0;
        read_patterns();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        if (n_items == 0) begin
            $display("no test items were read from the pattern file");
            err_count++;
        end else begin
            fork
                drive_items();
                collect_items();
            join
            drain_check();
        end
        sva_errors = dut0.u_sva.fail_count;
        $display("items %0d of %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 received, n_items, err_count, timeout_count, sva_errors);
        if (err_count == 0 && timeout_count == 0 && sva_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/exec_patterns.txt
# inst pc rs1 rs2 | expected rd_we rd_addr rd_data pc_next illegal | stall
# all columns hex; stall set holds out_ready_i low for a few cycles
002081b3 00000100 11111111 22222222 1 03 33333333 00000104 0 0
40208233 00000104 00000005 00000007 1 04 fffffffe 00000108 0 1
4020d2b3 00000108 80000010 00000024 1 05 f8000001 0000010c 0 0
0020a3b3 0000010c ffffffff 00000001 1 07 00000001 00000110 0 0
0020b433 00000110 ffffffff 00000001 1 08 00000000 00000114 0 0
0020c4b3 00000114 f0f0f0f0 ff00ff00 1 09 0ff00ff0 00000118 0 0
fff08513 00000118 00000010 00000000 1 0a 0000000f 0000011c 0 0
0f00f593 0000011c 12345678 00000000 1 0b 00000070 00000120 0 0
4080d613 00000120 80000000 00000000 1 0c ff800000 00000124 0 0
00309693 00000124 00000001 00000000 1 0d 00000008 00000128 0 1
12345737 00000128 00000000 00000000 1 0e 12345000 0000012c 0 0
00001797 00000130 00000000 00000000 1 0f 00001130 00000134 0 0
010000ef 00000200 00000000 00000000 1 01 00000204 00000210 0 0
003302e7 00000210 00001000 00000000 1 05 00000214 00001002 0 0
fe208ce3 00000300 00000005 00000005 0 00 00000000 000002f8 0 0
fe209ce3 00000304 00000005 00000005 0 00 00000000 00000308 0 0
0020c463 00000308 ffffffff 00000001 0 00 00000000 00000310 0 0
0020d463 00000310 00000001 ffffffff 0 00 00000000 00000318 0 1
0020e463 00000318 00000001 ffffffff 0 00 00000000 00000320 0 0
0020f463 00000320 00000001 ffffffff 0 00 00000000 00000324 0 0
00012083 00000400 00000000 00000000 0 00 00000000 00000404 1 0
4020f1b3 00000404 00000000 00000000 0 00 00000000 00000408 1 0
40309693 00000408 00000000 00000000 0 00 00000000 0000040c 1 0
0020a463 0000040c 00000000 00000000 0 00 00000000 00000410 1 0
0000000f 00000410 00000000 00000000 0 00 00000000 00000414 0 0
00000000 00000414 00000000 00000000 0 00 00000000 00000418 0 0

// File: src.f
hdl/rv_isa_pkg.sv
hdl/exec_pkg.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/exec_core.sv
testbench/exec_core_sva.sv
testbench/tb_exec_core.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log

TOP=tb_exec_core
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module "$TOP" -f src.f -o sim_exec_core
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_exec_core +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0
